//--- rtl/cpuPkg.sv
// ====================
// Shared definitions for the decode stage.
// Opcodes, control enums and the packed
// structs passed between pipeline stages.
// Modules pull this in by wildcard import.
// ====================

package cpuPkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_JR   = 6'h08,
        F_MFHI = 6'h10,
        F_MFLO = 6'h12,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpE;

    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extOpE;
    typedef enum logic [1:0] {SEL_REG, SEL_HI, SEL_LO, SEL_CP0} readSelE;
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JR} branchE;
    typedef enum logic [1:0] {EXC_NONE, EXC_FETCH, EXC_RI} exceptE;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        fetchExcept;  // fetch error seen upstream
    } ifIdBus;

    typedef struct packed {
        aluOpE       aluOp;
        extOpE       extOp;
        readSelE     readSel;
        branchE      branchType;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        useImm;       // operandB takes the immediate
        logic        isImmJump;    // j / jal
        logic [4:0]  dst;
        exceptE      exceptType;
    } ctrlBus;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] operandA;
        logic [31:0] operandB;
        logic [31:0] storeData;
        logic [31:0] imm32;
        ctrlBus      ctrl;
    } idExeBus;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic       rsRead;
        logic       rtRead;
        logic       isImmJump;
    } hazardBus;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] result;
    } wbBus;

endpackage

//--- rtl/stageReg.sv
// ====================
// Generic pipeline slot register.
// Flush loads the zero payload and wins over
// write; otherwise write loads d, else hold.
// ====================

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    wr,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;  // zero word decodes as sll r0, a nop
        end else if (wr) begin
            q <= d;
        end
    end

endmodule

//--- rtl/regFile.sv
// ====================
// 32 x 32 register file, two read ports.
// r0 reads zero; a same-cycle write-back to a
// read register is bypassed onto the read bus.
// ====================

module regFile
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  wbBus        wb,
    output logic [31:0] busA,
    output logic [31:0] busB
);

    logic [31:0] regs [32];
    logic        wbValid;

    assign wbValid = wb.regWrite && (wb.dst != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wb.dst] <= wb.result;
        end
    end

    // combinational reads with write-back bypass
    always_comb begin
        if (rs == 5'd0)
            busA = '0;
        else if (wbValid && (wb.dst == rs))
            busA = wb.result;
        else
            busA = regs[rs];

        if (rt == 5'd0)
            busB = '0;
        else if (wbValid && (wb.dst == rt))
            busB = wb.result;
        else
            busB = regs[rt];
    end

endmodule

//--- rtl/decoder.sv
// ====================
// Instruction decoder for the supported subset.
// Produces the control bundle and the rs/rt
// read flags used by the hazard unit.
// Unknown encodings raise a reserved-instr
// exception; fetch errors pass straight through.
// ====================

module decoder
    import cpuPkg::*;
(
    input  logic [31:0] instr,
    input  logic        fetchExcept,
    output ctrlBus      ctrl,
    output logic        rsRead,
    output logic        rtRead
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    ctrlBus     base;      // decode before exception override
    logic       reserved;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    always_comb begin
        base     = '0;
        reserved = 1'b0;
        rsRead   = 1'b0;
        rtRead   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                base.regWrite = 1'b1;  // most R-types write rd
                base.dst      = rd;
                rsRead        = 1'b1;
                rtRead        = 1'b1;
                case (funct)
                    F_ADDU: base.aluOp = ALU_ADD;
                    F_SUBU: base.aluOp = ALU_SUB;
                    F_AND:  base.aluOp = ALU_AND;
                    F_OR:   base.aluOp = ALU_OR;
                    F_XOR:  base.aluOp = ALU_XOR;
                    F_SLT:  base.aluOp = ALU_SLT;
                    F_SLL: begin
                        base.aluOp = ALU_SLL;
                        rsRead     = 1'b0;  // shamt replaces rs
                    end
                    F_JR: begin
                        base.branchType = BR_JR;
                        base.regWrite   = 1'b0;
                        rtRead          = 1'b0;
                    end
                    F_MFHI, F_MFLO: begin
                        // 0 + HI/LO through the adder
                        base.aluOp   = ALU_ADD;
                        base.readSel = (funct == F_MFHI) ? SEL_HI : SEL_LO;
                        rsRead       = 1'b0;
                        rtRead       = 1'b0;
                    end
                    default: reserved = 1'b1;
                endcase
            end
            OP_J:   base.isImmJump = 1'b1;
            OP_JAL: begin
                base.isImmJump = 1'b1;
                base.regWrite  = 1'b1;
                base.dst       = 5'd31;  // link register
            end
            OP_BEQ, OP_BNE: begin
                base.branchType = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                base.extOp      = EXT_SIGN;
                rsRead          = 1'b1;
                rtRead          = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LW: begin
                base.useImm   = 1'b1;
                base.regWrite = 1'b1;
                base.dst      = rt;
                base.memRead  = (opcode == OP_LW);
                rsRead        = 1'b1;
                case (opcode)
                    OP_SLTI: base.aluOp = ALU_SLT;
                    OP_ANDI: base.aluOp = ALU_AND;
                    OP_ORI:  base.aluOp = ALU_OR;
                    OP_XORI: base.aluOp = ALU_XOR;
                    default: base.aluOp = ALU_ADD;  // addiu, lw address
                endcase
                // logical immediates are zero extended
                if (opcode == OP_ADDIU || opcode == OP_SLTI || opcode == OP_LW)
                    base.extOp = EXT_SIGN;
                else
                    base.extOp = EXT_ZERO;
            end
            OP_LUI: begin
                base.aluOp    = ALU_LUI;
                base.extOp    = EXT_UPPER;
                base.useImm   = 1'b1;
                base.regWrite = 1'b1;
                base.dst      = rt;
            end
            OP_SW: begin
                base.aluOp    = ALU_ADD;
                base.extOp    = EXT_SIGN;
                base.useImm   = 1'b1;
                base.memWrite = 1'b1;
                rsRead        = 1'b1;
                rtRead        = 1'b1;  // store data
            end
            OP_COP0: begin
                // only mfc0 (rs field 0); writes rt from cp0
                if (rs == 5'd0) begin
                    base.aluOp    = ALU_ADD;
                    base.readSel  = SEL_CP0;
                    base.regWrite = 1'b1;
                    base.dst      = rt;
                end else begin
                    reserved = 1'b1;
                end
            end
            default: reserved = 1'b1;
        endcase
    end

    always_comb begin
        ctrl = base;
        // writes to r0 are dropped here, so sll r0 is a true nop
        ctrl.regWrite = base.regWrite && (base.dst != 5'd0);
        if (fetchExcept || reserved) begin
            ctrl.exceptType = fetchExcept ? EXC_FETCH : EXC_RI;
            ctrl.regWrite   = 1'b0;
            ctrl.memRead    = 1'b0;
            ctrl.memWrite   = 1'b0;
        end
    end

endmodule

//--- rtl/operandSelect.sv
// ====================
// Operand assembly for the execute stage.
// Extends the immediate and picks the second
// operand from regs, HI, LO or CP0.
// ====================

module operandSelect
    import cpuPkg::*;
(
    input  logic [31:0] instr,
    input  ctrlBus      ctrl,
    input  logic [31:0] busA,
    input  logic [31:0] busB,
    input  logic [31:0] hiBus,
    input  logic [31:0] loBus,
    input  logic [31:0] cp0Bus,
    output logic [31:0] operandA,
    output logic [31:0] operandB,
    output logic [31:0] storeData,
    output logic [31:0] imm32
);

    logic [15:0] imm16;
    logic [4:0]  shamt;

    assign imm16 = instr[15:0];
    assign shamt = instr[10:6];

    always_comb begin
        case (ctrl.extOp)
            EXT_SIGN:  imm32 = {{16{imm16[15]}}, imm16};
            EXT_UPPER: imm32 = {imm16, 16'h0000};  // lui
            default:   imm32 = {16'h0000, imm16};
        endcase
    end

    always_comb begin
        case (ctrl.readSel)
            SEL_HI:  storeData = hiBus;
            SEL_LO:  storeData = loBus;
            SEL_CP0: storeData = cp0Bus;
            default: storeData = busB;
        endcase
    end

    assign operandB = ctrl.useImm ? imm32 : storeData;
    // sll shifts rt by shamt, rs unused
    assign operandA = (ctrl.aluOp == ALU_SLL) ? {27'd0, shamt} : busA;

endmodule

//--- rtl/idStage.sv
// ====================
// Decode stage top level.
// IF/ID register -> decode, register read and
// operand select -> ID/EXE register.
// hazardOut is combinational from IF/ID.
// ====================

module idStage
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  ifIdBus      fetchIn,
    input  logic        idWr,
    input  logic        idFlush,
    input  logic        exeWr,
    input  logic        exeFlush,
    input  wbBus        wbIn,
    input  logic [31:0] hiBus,
    input  logic [31:0] loBus,
    input  logic [31:0] cp0Bus,
    output idExeBus     exeOut,
    output hazardBus    hazardOut
);

    ifIdBus      ifId;
    ctrlBus      ctrl;
    idExeBus     exeIn;
    logic        rsRead;
    logic        rtRead;
    logic [31:0] busA;
    logic [31:0] busB;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] storeData;
    logic [31:0] imm32;

    stageReg #(.payloadT(ifIdBus)) ifIdReg (
        .clk   (clk),
        .arstN (arstN),
        .wr    (idWr),
        .flush (idFlush),
        .d     (fetchIn),
        .q     (ifId)
    );

    regFile rf (
        .clk   (clk),
        .arstN (arstN),
        .rs    (ifId.instr[25:21]),
        .rt    (ifId.instr[20:16]),
        .wb    (wbIn),
        .busA  (busA),
        .busB  (busB)
    );

    decoder dec (
        .instr       (ifId.instr),
        .fetchExcept (ifId.fetchExcept),
        .ctrl        (ctrl),
        .rsRead      (rsRead),
        .rtRead      (rtRead)
    );

    operandSelect opSel (
        .instr     (ifId.instr),
        .ctrl      (ctrl),
        .busA      (busA),
        .busB      (busB),
        .hiBus     (hiBus),
        .loBus     (loBus),
        .cp0Bus    (cp0Bus),
        .operandA  (operandA),
        .operandB  (operandB),
        .storeData (storeData),
        .imm32     (imm32)
    );

    // ID/EXE payload
    assign exeIn.pc        = ifId.pc;
    assign exeIn.instr     = ifId.instr;
    assign exeIn.operandA  = operandA;
    assign exeIn.operandB  = operandB;
    assign exeIn.storeData = storeData;
    assign exeIn.imm32     = imm32;
    assign exeIn.ctrl      = ctrl;

    stageReg #(.payloadT(idExeBus)) idExeReg (
        .clk   (clk),
        .arstN (arstN),
        .wr    (exeWr),
        .flush (exeFlush),
        .d     (exeIn),
        .q     (exeOut)
    );

    assign hazardOut.rs        = ifId.instr[25:21];
    assign hazardOut.rt        = ifId.instr[20:16];
    assign hazardOut.rsRead    = rsRead;
    assign hazardOut.rtRead    = rtRead;
    assign hazardOut.isImmJump = ctrl.isImmJump;  // j/jal redirect at decode

endmodule

//--- testbench/idStage_sva.sv
// ====================
// Concurrent checks bound into the decode stage.
// Flush clears side effects, r0 reads zero and a
// reserved instruction never writes a register.
// ====================

module idStage_sva
    import cpuPkg::*;
(
    input logic        clk,
    input logic        arstN,
    input logic        exeFlush,
    input idExeBus     exeOut,
    input ifIdBus      ifId,
    input logic [31:0] busA,
    input logic [31:0] busB,
    input ctrlBus      ctrl
);

    flushClears: assert property (@(posedge clk) disable iff (!arstN)
        exeFlush |=> !exeOut.ctrl.regWrite && !exeOut.ctrl.memRead && !exeOut.ctrl.memWrite)
        else $error("ID/EXE flush left a write or memory flag set");

    zeroRegA: assert property (@(posedge clk) disable iff (!arstN)
        (ifId.instr[25:21] == 5'd0) |-> (busA == 32'd0))
        else $error("read of r0 on port A gave a nonzero value");

    zeroRegB: assert property (@(posedge clk) disable iff (!arstN)
        (ifId.instr[20:16] == 5'd0) |-> (busB == 32'd0))
        else $error("read of r0 on port B gave a nonzero value");

    // reserved encodings must not touch the register file
    riNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        (ctrl.exceptType == EXC_RI) |-> !ctrl.regWrite)
        else $error("reserved instruction carried regWrite");

endmodule

bind idStage idStage_sva sva (
    .clk      (clk),
    .arstN    (arstN),
    .exeFlush (exeFlush),
    .exeOut   (exeOut),
    .ifId     (ifId),
    .busA     (busA),
    .busB     (busB),
    .ctrl     (ctrl)
);

//--- testbench/tb_idStage.sv
// ====================
// Testbench for the decode stage.
// Streams random and directed instructions, keeps
// its own register model and checks exeOut and
// hazardOut against a reference decode each cycle.
// ====================

module tb_idStage
    import cpuPkg::*;
();

    localparam int numKinds     = 23;
    localparam int decodeRounds = 12;
    localparam int stallCycles  = 300;
    localparam int excRounds    = 8;
    localparam int testCycles   = 16 + 2 + numKinds * decodeRounds + 3 * decodeRounds + 9
                                  + 4 + stallCycles + 7 * excRounds + 4;

    localparam logic [5:0] rFn [10] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR,
                                        F_SLT, F_SLL, F_JR, F_MFHI, F_MFLO};
    localparam logic [5:0] iOp [12] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                        OP_LW, OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JAL};
    localparam logic [5:0] badOp [4] = '{6'h01, 6'h08, 6'h20, 6'h3f};

    logic        clk;
    logic        arstN;
    ifIdBus      fetchIn;
    logic        idWr;
    logic        idFlush;
    logic        exeWr;
    logic        exeFlush;
    wbBus        wbIn;
    logic [31:0] hiBus;
    logic [31:0] loBus;
    logic [31:0] cp0Bus;
    idExeBus     exeOut;
    hazardBus    hazardOut;

    int          seed = 32'h67c5a3a7;
    int          checkCount = 0;
    int          errorCount = 0;
    string       testName;
    logic [31:0] pcNext = 32'h0040_0000;
    logic [31:0] regModel [32];
    ifIdBus      ifIdModel = '0;     // what the IF/ID register should hold
    idExeBus     lastExe = '0;
    idExeBus     expQ [$];

    idStage dut (
        .clk       (clk),
        .arstN     (arstN),
        .fetchIn   (fetchIn),
        .idWr      (idWr),
        .idFlush   (idFlush),
        .exeWr     (exeWr),
        .exeFlush  (exeFlush),
        .wbIn      (wbIn),
        .hiBus     (hiBus),
        .loBus     (loBus),
        .cp0Bus    (cp0Bus),
        .exeOut    (exeOut),
        .hazardOut (hazardOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference decode, written from the instruction set rules
    function automatic ctrlBus decodeRef(input logic [31:0] ins, input logic fexc);
        ctrlBus     c;
        logic [5:0] op;
        logic [5:0] fn;
        logic       ri;
        op = ins[31:26];
        fn = ins[5:0];
        c  = '0;
        ri = 1'b0;
        if (op == OP_SPECIAL) begin
            c.dst      = ins[15:11];
            c.regWrite = (fn != F_JR);
            case (fn)
                F_ADDU, F_MFHI, F_MFLO: c.aluOp = ALU_ADD;
                F_SUBU: c.aluOp = ALU_SUB;
                F_AND:  c.aluOp = ALU_AND;
                F_OR:   c.aluOp = ALU_OR;
                F_XOR:  c.aluOp = ALU_XOR;
                F_SLT:  c.aluOp = ALU_SLT;
                F_SLL:  c.aluOp = ALU_SLL;
                F_JR:   c.branchType = BR_JR;
                default: ri = 1'b1;
            endcase
            if (fn == F_MFHI) c.readSel = SEL_HI;
            if (fn == F_MFLO) c.readSel = SEL_LO;
        end else begin
            case (op)
                OP_J:   c.isImmJump = 1'b1;
                OP_JAL: begin
                    c.isImmJump = 1'b1;
                    c.regWrite  = 1'b1;
                    c.dst       = 5'd31;
                end
                OP_BEQ, OP_BNE: begin
                    c.branchType = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
                    c.extOp      = EXT_SIGN;
                end
                OP_ADDIU, OP_SLTI, OP_LW, OP_SW: begin
                    c.extOp    = EXT_SIGN;
                    c.useImm   = 1'b1;
                    c.aluOp    = (op == OP_SLTI) ? ALU_SLT : ALU_ADD;
                    c.regWrite = (op != OP_SW);
                    c.dst      = (op == OP_SW) ? 5'd0 : ins[20:16];
                    c.memRead  = (op == OP_LW);
                    c.memWrite = (op == OP_SW);
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                    c.useImm   = 1'b1;
                    c.regWrite = 1'b1;
                    c.dst      = ins[20:16];
                    c.aluOp    = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR : ALU_XOR;
                end
                OP_LUI: begin
                    c.aluOp    = ALU_LUI;
                    c.extOp    = EXT_UPPER;
                    c.useImm   = 1'b1;
                    c.regWrite = 1'b1;
                    c.dst      = ins[20:16];
                end
                OP_COP0: begin
                    if (ins[25:21] == 5'd0) begin  // mfc0 only
                        c.aluOp    = ALU_ADD;
                        c.readSel  = SEL_CP0;
                        c.regWrite = 1'b1;
                        c.dst      = ins[20:16];
                    end else begin
                        ri = 1'b1;
                    end
                end
                default: ri = 1'b1;
            endcase
        end
        if (c.dst == 5'd0) c.regWrite = 1'b0;
        if (fexc || ri) begin
            c.exceptType = fexc ? EXC_FETCH : EXC_RI;
            c.regWrite   = 1'b0;
            c.memRead    = 1'b0;
            c.memWrite   = 1'b0;
        end
        return c;
    endfunction

    // {rsRead, rtRead}
    function automatic logic [1:0] readFlags(input logic [31:0] ins);
        case (ins[31:26])
            OP_SPECIAL: begin
                case (ins[5:0])
                    F_SLL:          return 2'b01;
                    F_JR:           return 2'b10;
                    F_MFHI, F_MFLO: return 2'b00;
                    default:        return 2'b11;
                endcase
            end
            OP_BEQ, OP_BNE, OP_SW: return 2'b11;
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LW: return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] readReg(input logic [4:0] idx);
        if (idx == 5'd0) return '0;
        if (wbIn.regWrite && wbIn.dst == idx) return wbIn.result;  // same-cycle bypass
        return regModel[idx];
    endfunction

    function automatic idExeBus exeRef(input ifIdBus f);
        idExeBus     e;
        logic [15:0] imm;
        imm     = f.instr[15:0];
        e.pc    = f.pc;
        e.instr = f.instr;
        e.ctrl  = decodeRef(f.instr, f.fetchExcept);
        case (e.ctrl.extOp)
            EXT_SIGN:  e.imm32 = {{16{imm[15]}}, imm};
            EXT_UPPER: e.imm32 = {imm, 16'h0000};
            default:   e.imm32 = {16'h0000, imm};
        endcase
        case (e.ctrl.readSel)
            SEL_HI:  e.storeData = hiBus;
            SEL_LO:  e.storeData = loBus;
            SEL_CP0: e.storeData = cp0Bus;
            default: e.storeData = readReg(f.instr[20:16]);
        endcase
        e.operandB = e.ctrl.useImm ? e.imm32 : e.storeData;
        e.operandA = (e.ctrl.aluOp == ALU_SLL) ? {27'd0, f.instr[10:6]} : readReg(f.instr[25:21]);
        return e;
    endfunction

    function automatic hazardBus hazardRef(input logic [31:0] ins);
        hazardBus   h;
        ctrlBus     c;
        logic [1:0] rd;
        c           = decodeRef(ins, 1'b0);
        rd          = readFlags(ins);
        h.rs        = ins[25:21];
        h.rt        = ins[20:16];
        h.rsRead    = rd[1];
        h.rtRead    = rd[0];
        h.isImmJump = c.isImmJump;
        return h;
    endfunction

    function automatic logic [31:0] makeInstr(input int kind);
        logic [31:0] r;
        r = $random(seed);
        if (kind < 10) return {6'h00, r[25:6], rFn[kind]};
        if (kind < 22) return {iOp[kind - 10], r[25:0]};
        return {OP_COP0, 5'd0, r[20:0]};
    endfunction

    function automatic wbBus randWb();
        wbBus        w;
        logic [31:0] r;
        r          = $random(seed);
        w.regWrite = r[0];
        w.dst      = r[5:1];
        w.result   = $random(seed);
        return w;
    endfunction

    task automatic checkExe(input string name, input idExeBus exp, input idExeBus act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("[ERROR] %s exeOut expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkHazard(input string name, input hazardBus exp, input hazardBus act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("[ERROR] %s hazardOut expected %h actual %h", name, exp, act);
        end
    endtask

    // one clock of stimulus, hi/lo/cp0 always random
    task automatic driveCycle(input logic [31:0] ins, input logic fexc, input logic iw,
                              input logic ew, input logic ifl, input logic efl, input wbBus w);
        @(posedge clk);
        fetchIn.pc          <= pcNext;
        fetchIn.instr       <= ins;
        fetchIn.fetchExcept <= fexc;
        idWr                <= iw;
        exeWr               <= ew;
        idFlush             <= ifl;
        exeFlush            <= efl;
        wbIn                <= w;
        hiBus               <= $random(seed);
        loBus               <= $random(seed);
        cp0Bus              <= $random(seed);
        pcNext              = pcNext + 32'd4;
    endtask

    // model of both stage registers and the register file
    always @(posedge clk) begin
        if (arstN) begin
            if (exeFlush) begin
                expQ.push_back(idExeBus'(0));
            end else if (exeWr) begin
                expQ.push_back(exeRef(ifIdModel));
            end
            if (idFlush) ifIdModel = '0;
            else if (idWr) ifIdModel = fetchIn;
            if (wbIn.regWrite && wbIn.dst != 5'd0) regModel[wbIn.dst] = wbIn.result;
        end
    end

    always @(negedge clk) begin
        if (arstN) begin
            while (expQ.size() > 0) begin
                lastExe = expQ.pop_front();
            end
            checkExe(testName, lastExe, exeOut);  // also catches a slot that fails to hold
            checkHazard(testName, hazardRef(ifIdModel.instr), hazardOut);
        end
    end

    initial begin
        #((testCycles + 200) * 10);
        $display("watchdog expired, run did not end within %0d cycles", testCycles + 200);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  k;
        wbBus        w;
        arstN    = 1'b0;
        fetchIn  = '0;
        idWr     = 1'b0;
        idFlush  = 1'b0;
        exeWr    = 1'b0;
        exeFlush = 1'b0;
        wbIn     = '0;
        hiBus    = '0;
        loBus    = '0;
        cp0Bus   = '0;
        for (int i = 0; i < 32; i++) regModel[i] = '0;
        testName = "reset";
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        repeat (2) driveCycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);

        testName = "decode";
        for (int n = 0; n < decodeRounds; n++) begin
            for (int kind = 0; kind < numKinds; kind++) begin
                driveCycle(makeInstr(kind), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            end
        end

        testName = "mfMoves";
        for (int n = 0; n < decodeRounds; n++) begin
            driveCycle(makeInstr(8), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            driveCycle(makeInstr(9), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            driveCycle(makeInstr(22), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
        end

        testName = "bypass";
        for (int n = 0; n < 3; n++) begin
            k = (n == 2) ? 5'd0 : (n == 0) ? 5'd5 : 5'd17;
            w.regWrite = 1'b1;
            w.dst      = k;
            w.result   = $random(seed);
            driveCycle({6'h00, k, k, 5'd9, 5'd0, F_ADDU}, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, '0);
            driveCycle(makeInstr(0), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, w);  // write k under the read
            driveCycle({6'h00, k, k, 5'd9, 5'd0, F_OR}, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, '0);
        end

        testName = "flush";
        driveCycle(makeInstr(8), 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, randWb());
        driveCycle(makeInstr(14), 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, randWb());
        driveCycle(makeInstr(15), 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, randWb());
        driveCycle(makeInstr(2), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());

        testName = "stall";
        for (int n = 0; n < stallCycles; n++) begin
            r = $random(seed);
            driveCycle(makeInstr(int'(r[15:8]) % numKinds), 1'b0, r[0], r[1],
                       r[6:2] == 5'd0, r[31:27] == 5'd0, randWb());
        end

        testName = "exception";
        for (int n = 0; n < excRounds; n++) begin
            r = $random(seed);
            for (int i = 0; i < 4; i++) begin
                driveCycle({badOp[i], r[25:0]}, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            end
            driveCycle({6'h00, r[25:6], 6'h20}, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            driveCycle({OP_COP0, 5'd4, r[20:0]}, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
            driveCycle(makeInstr(n % numKinds), 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, randWb());
        end

        testName = "drain";
        repeat (4) driveCycle('0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, '0);
        @(negedge clk);
        @(negedge clk);
        @(posedge clk);  // let the last negedge compare finish first

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/cpuPkg.sv
rtl/stageReg.sv
rtl/regFile.sv
rtl/decoder.sv
rtl/operandSelect.sv
rtl/idStage.sv
testbench/idStage_sva.sv
testbench/tb_idStage.sv
